// ==== dv/lane_core_tb.sv ====
// Testbench for the lane core: clock, reset, APB driver, stimulus reader, checks, timeout
`timescale 1ns/1ps

module lane_core_tb import lane_pkg::*; ();

	localparam string STIM_FILE = "dv/lane_stimulus.txt";
	localparam int CYCLES_PER_LINE = 40;

	// One stimulus line without its name
	typedef struct packed {
		logic write;
		logic [7:0] addr;
		logic [31:0] data;	// Compare mask on reads
		logic [31:0] exp_rdata;
		logic exp_err;
	} stim_t;

	logic clock;
	logic reset;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;

	integer seed;
	int pass_count = 0;
	int fail_count = 0;
	int cycle_count = 0;
	int cycle_limit = 100;
	stim_t entries[$];
	string names[$];

	lane_core #(.DATA_W(DATA_W), .NUM_REGS(NUM_REGS)) u_lane_core (
		.clock		(clock),
		.reset		(reset),
		.apb_req	(apb_req),
		.apb_rsp	(apb_rsp)
	);

	initial clock = 1'b0;
	always #50 clock = ~clock;

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Run stopped after %0d cycles because the DUT never finished the stimulus",
				cycle_count);
			$display("test failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// Stimulus file
	////////////////////////////////////////
	task automatic load_stimulus();
		int fd;
		int n;
		int err_val;
		string line;
		string name;
		string dir;
		logic [7:0] addr;
		logic [31:0] data;
		logic [31:0] exp_rdata;
		stim_t entry;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file %s", STIM_FILE);
			fail_count++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.substr(0, 0) == "#") begin
				continue;	// Blank or comment
			end
			n = $sscanf(line, "%s %s %h %h %h %d", name, dir, addr, data, exp_rdata, err_val);
			if (n != 6 || (dir != "W" && dir != "R")) begin
				$display("Stimulus line could not be parsed: %s", line);
				fail_count++;
				continue;
			end
			entry.write = (dir == "W");
			entry.addr = addr;
			entry.data = data;
			entry.exp_rdata = exp_rdata;
			entry.exp_err = (err_val != 0);
			entries.push_back(entry);
			names.push_back(name);
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////
	// APB driver
	////////////////////////////////////////
	task automatic drive_idle();
		apb_req.psel = 1'b0;
		apb_req.penable = 1'b0;
		apb_req.pwrite = 1'b0;
		apb_req.paddr = 8'h00;
		apb_req.pwdata = 32'h0;
	endtask

	task automatic apb_transfer(input stim_t entry, output logic [31:0] rdata, output logic err);
		logic done;
		rdata = 32'h0;
		err = 1'b0;
		done = 1'b0;
		@(negedge clock);
		apb_req.psel = 1'b1;	// Setup phase
		apb_req.penable = 1'b0;
		apb_req.pwrite = entry.write;
		apb_req.paddr = entry.addr;
		apb_req.pwdata = entry.write ? entry.data : 32'h0;
		@(negedge clock);
		apb_req.penable = 1'b1;
		while (!done) begin
			@(posedge clock);	// Pre-edge values
			if (apb_rsp.pready) begin
				done = 1'b1;
				rdata = apb_rsp.prdata;
				err = apb_rsp.pslverr;
			end
		end
	endtask

	task automatic check_entry(input string name, input stim_t entry, input logic [31:0] rdata,
		input logic err);
		logic ok;
		ok = 1'b1;
		if (err !== entry.exp_err) begin
			$display("FAIL %s pslverr expected %0b actual %0b", name, entry.exp_err, err);
			ok = 1'b0;
		end
		if (!entry.write && (((rdata ^ entry.exp_rdata) & entry.data) !== 32'h0)) begin
			$display("FAIL %s expected %08h actual %08h", name, entry.exp_rdata, rdata);
			ok = 1'b0;
		end
		if (ok) begin
			pass_count++;
			$display("PASS %s", name);
		end else begin
			fail_count++;
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial begin
		logic [31:0] rdata;
		logic err;
		int gap;
		seed = 32'hacf42654;
		drive_idle();
		reset = 1'b1;
		load_stimulus();
		cycle_limit = CYCLES_PER_LINE * names.size() + 100;
		repeat (5) @(negedge clock);
		reset = 1'b0;

		foreach (entries[i]) begin
			apb_transfer(entries[i], rdata, err);
			check_entry(names[i], entries[i], rdata, err);
			gap = {$random(seed)} % 4;
			if (gap > 0) begin
				@(negedge clock);
				drive_idle();
				repeat (gap - 1) @(negedge clock);
			end
		end
		@(negedge clock);
		drive_idle();

		$display("Checks passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0 && names.size() > 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== dv/lane_stimulus.txt ====
# name, W or R, address, write data (bits compared on reads), expected read data, expected pslverr
# All numbers hex except pslverr
reset_r0 R 40 ffffffff 00000000 0
reset_r5 R 54 ffffffff 00000000 0
reset_r10 R 68 ffffffff 00000000 0
reset_r15 R 7c ffffffff 00000000 0
reset_status R 04 ffffffff 00000001 0
movi_r2 W 00 50200123 00000000 0
movi_r3 W 00 50300ffe 00000000 0
read_r2 R 48 ffffffff 00000123 0
read_r3 R 4c ffffffff fffffffe 0
add_r6 W 00 10623000 00000000 0
sub_r7 W 00 20762000 00000000 0
and_r8 W 00 30876000 00000000 0
xor_r9 W 00 40983000 00000000 0
chain_r9 R 64 ffffffff fffffede 0
chain_r7 R 5c ffffffff fffffffe 0
chain_r8 R 60 ffffffff 00000120 0
cmplt_true_r10 W 00 60a32000 00000000 0
cmplt_false_r11 W 00 60b23000 00000000 0
movi_masked_r10 W 00 58a00055 00000000 0
movi_masked_r11 W 00 58b00066 00000000 0
masked_r10 R 68 ffffffff 00000055 0
masked_r11 R 6c ffffffff 00000000 0
mask_status R 04 ffffffff 04000001 0
lane_off W 00 70000000 00000000 0
add_off_r2 W 00 10223000 00000000 0
off_r2 R 48 ffffffff 00000123 0
off_status R 04 ffffffff 04000000 0
lane_on W 00 80000000 00000000 0
add_on_r2 W 00 10223000 00000000 0
on_r2 R 48 ffffffff 00000121 0
on_status R 04 ffffffff 04000001 0
burst_r12 W 00 50c00011 00000000 0
burst_r13 W 00 50d00022 00000000 0
burst_r14 W 00 50e00033 00000000 0
burst_status R 04 fffffffd 04000001 0
burst_read_r14 R 78 ffffffff 00000033 0
err_rd_cmd R 00 00000000 00000000 1
err_wr_status W 04 00000001 00000000 1
err_rd_unmapped R 08 00000000 00000000 1
err_wr_reg W 40 00000001 00000000 1
err_rd_range R 80 00000000 00000000 1

// ==== hw/lane_apb_port.sv ====
// APB slave for the lane: address decode, issue requests, register read return, status word
`timescale 1ns/1ps

module lane_apb_port import lane_pkg::*; #(
	parameter int DATA_W = lane_pkg::DATA_W,
	parameter int NUM_REGS = lane_pkg::NUM_REGS
) (
	input	logic					clock,
	input	logic					reset,
	input	apb_req_t				apb_req,
	output	apb_rsp_t				apb_rsp,
	output	issue_t					req,
	input	logic					accept,
	input	logic					read_done,
	input	logic [DATA_W-1:0]		read_data,
	input	logic					lane_en,
	input	logic					busy,
	input	logic [NUM_REGS-1:0]	mask
);

	logic access;
	logic [7:0] reg_off;
	logic hit_cmd;
	logic hit_status;
	logic hit_reg;
	logic rd_pending;	// Register read in the pipeline
	logic [31:0] status;

	assign access = apb_req.psel & apb_req.penable;
	assign reg_off = apb_req.paddr - ADDR_REG_BASE;

	// Address map
	assign hit_cmd = apb_req.pwrite & (apb_req.paddr == ADDR_CMD);
	assign hit_status = ~apb_req.pwrite & (apb_req.paddr == ADDR_STATUS);
	assign hit_reg = ~apb_req.pwrite & (apb_req.paddr >= ADDR_REG_BASE) &
		(reg_off < 8'(4 * NUM_REGS)) & (reg_off[1:0] == 2'b00);

	always_comb begin
		req = '0;
		if (hit_cmd) begin
			req.valid = access;
			req.cmd = cmd_t'(apb_req.pwdata);
		end else if (hit_reg) begin
			// Read goes down the pipe as a source-only item
			req.valid = access & ~rd_pending;
			req.rd_only = 1'b1;
			req.cmd.opcode = NOP;
			req.cmd.src1 = reg_idx_t'(reg_off[7:2]);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_pending <= 1'b0;
		end else if (req.valid & req.rd_only & accept) begin
			rd_pending <= 1'b1;
		end else if (read_done) begin
			rd_pending <= 1'b0;
		end
	end

	always_comb begin
		status = '0;
		status[0] = lane_en;
		status[1] = busy;
		status[16 +: NUM_REGS] = mask;
	end

	always_comb begin
		apb_rsp = '0;
		if (access) begin
			if (hit_cmd) begin
				apb_rsp.pready = accept;
			end else if (hit_status) begin
				apb_rsp.pready = 1'b1;
				apb_rsp.prdata = status;
			end else if (hit_reg) begin
				apb_rsp.pready = rd_pending & read_done;
				apb_rsp.prdata = 32'(read_data);
			end else begin
				apb_rsp.pready = 1'b1;	// Unmapped or wrong direction
				apb_rsp.pslverr = 1'b1;
			end
		end
	end

endmodule

// ==== hw/lane_core.sv ====
// Lane top level: APB port, issue, operand fetch with even and odd banks, execute, write-back
`timescale 1ns/1ps

module lane_core import lane_pkg::*; #(
	parameter int DATA_W = lane_pkg::DATA_W,
	parameter int NUM_REGS = lane_pkg::NUM_REGS
) (
	input	logic		clock,
	input	logic		reset,
	input	apb_req_t	apb_req,
	output	apb_rsp_t	apb_rsp
);

	issue_t req;
	issue_t issued;
	logic accept;
	logic busy;
	fetch_t fetched;
	result_t result;
	logic retire;
	reg_idx_t retire_dst;
	logic read_done;
	logic [DATA_W-1:0] read_data;
	logic lane_en;
	logic [NUM_REGS-1:0] mask;

	bank_idx_t even_rd_idx_a;
	bank_idx_t even_rd_idx_b;
	bank_idx_t odd_rd_idx_a;
	bank_idx_t odd_rd_idx_b;
	logic [DATA_W-1:0] even_rd_data_a;
	logic [DATA_W-1:0] even_rd_data_b;
	logic [DATA_W-1:0] odd_rd_data_a;
	logic [DATA_W-1:0] odd_rd_data_b;
	logic even_wr_en;
	logic odd_wr_en;
	bank_idx_t even_wr_idx;
	bank_idx_t odd_wr_idx;
	logic [DATA_W-1:0] even_wr_data;
	logic [DATA_W-1:0] odd_wr_data;

	////////////////////////////////////////
	// Host side
	////////////////////////////////////////
	lane_apb_port #(.DATA_W(DATA_W), .NUM_REGS(NUM_REGS)) u_apb_port (.*);

	lane_issue #(.NUM_REGS(NUM_REGS)) u_issue (.*);

	////////////////////////////////////////
	// Operands and execute
	////////////////////////////////////////
	lane_operand_fetch u_operand_fetch (.*);

	lane_reg_bank #(.DATA_W(DATA_W), .DEPTH(NUM_REGS / 2)) u_bank_even (
		.clock		(clock),
		.reset		(reset),
		.rd_idx_a	(even_rd_idx_a),
		.rd_idx_b	(even_rd_idx_b),
		.rd_data_a	(even_rd_data_a),
		.rd_data_b	(even_rd_data_b),
		.wr_en		(even_wr_en),
		.wr_idx		(even_wr_idx),
		.wr_data	(even_wr_data)
	);

	lane_reg_bank #(.DATA_W(DATA_W), .DEPTH(NUM_REGS / 2)) u_bank_odd (
		.clock		(clock),
		.reset		(reset),
		.rd_idx_a	(odd_rd_idx_a),
		.rd_idx_b	(odd_rd_idx_b),
		.rd_data_a	(odd_rd_data_a),
		.rd_data_b	(odd_rd_data_b),
		.wr_en		(odd_wr_en),
		.wr_idx		(odd_wr_idx),
		.wr_data	(odd_wr_data)
	);

	lane_exec u_exec (.*);

	lane_writeback #(.DATA_W(DATA_W), .NUM_REGS(NUM_REGS)) u_writeback (.*);	// Mask and enable

endmodule

// ==== hw/lane_exec.sv ====
// Execute stage: ALU, signed compare, result register
`timescale 1ns/1ps

module lane_exec import lane_pkg::*; (
	input	logic		clock,
	input	logic		reset,
	input	fetch_t		fetched,
	output	result_t	result
);

	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] b;
	logic [DATA_W-1:0] alu_out;
	logic cmp;

	assign a = fetched.opnd_a;
	assign b = fetched.opnd_b;
	assign cmp = $signed(a) < $signed(b);

	always_comb begin
		alu_out = '0;
		if (fetched.issue.rd_only) begin
			alu_out = a;	// Host read
		end else begin
			case (fetched.issue.cmd.opcode)
				ADD: alu_out = a + b;
				SUB: alu_out = a - b;
				AND: alu_out = a & b;
				XOR: alu_out = a ^ b;
				MOVI: alu_out = b;	// Immediate already in b
				CMPLT: alu_out = DATA_W'(cmp);
				default: alu_out = '0;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			result.valid <= 1'b0;
		end else begin
			result.valid <= fetched.issue.valid;
		end
		result.rd_only <= fetched.issue.rd_only;
		result.opcode <= fetched.issue.cmd.opcode;
		result.dst <= fetched.issue.cmd.dst;
		result.masked <= fetched.issue.cmd.masked;
		result.data <= alu_out;
		result.cmp <= cmp;
	end

endmodule

// ==== hw/lane_issue.sv ====
// Issue stage: register scoreboard, source hazard check, issue register
`timescale 1ns/1ps

module lane_issue import lane_pkg::*; #(
	parameter int NUM_REGS = lane_pkg::NUM_REGS
) (
	input	logic		clock,
	input	logic		reset,
	input	issue_t		req,
	output	logic		accept,
	output	issue_t		issued,
	input	logic		retire,
	input	reg_idx_t	retire_dst,
	output	logic		busy
);

	logic [NUM_REGS-1:0] pending;
	logic [NUM_REGS-1:0] set_bits;
	logic [NUM_REGS-1:0] clr_bits;
	logic use_srcs;
	logic hazard;
	logic req_writes;
	logic issued_writes;
	logic fetch_writes;	// Write in the fetch stage
	reg_idx_t fetch_dst;
	logic younger_hit;

	assign use_srcs = reads_srcs(req.cmd.opcode);
	assign hazard = ((use_srcs | req.rd_only) & pending[req.cmd.src1]) |
		(use_srcs & pending[req.cmd.src2]);
	assign accept = req.valid & ~hazard;

	assign req_writes = ~req.rd_only & writes_reg(req.cmd.opcode);
	assign issued_writes = issued.valid & ~issued.rd_only & writes_reg(issued.cmd.opcode);

	// A younger write to the same register keeps it pending
	assign younger_hit = (issued_writes & (issued.cmd.dst == retire_dst)) |
		(fetch_writes & (fetch_dst == retire_dst));

	always_comb begin
		set_bits = '0;
		clr_bits = '0;
		if (accept & req_writes) begin
			set_bits[req.cmd.dst] = 1'b1;
		end
		if (retire & ~younger_hit) begin
			clr_bits[retire_dst] = 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pending <= '0;
			fetch_writes <= 1'b0;
			issued.valid <= 1'b0;
		end else begin
			pending <= (pending & ~clr_bits) | set_bits;	// Set wins
			fetch_writes <= issued_writes;
			issued.valid <= accept;
		end
		fetch_dst <= issued.cmd.dst;
		issued.rd_only <= req.rd_only;
		issued.cmd <= req.cmd;
	end

	assign busy = |pending;

endmodule

// ==== hw/lane_operand_fetch.sv ====
// Operand fetch: bank routing, read data select, immediate, fetch register
`timescale 1ns/1ps

module lane_operand_fetch import lane_pkg::*; (
	input	logic				clock,
	input	logic				reset,
	input	issue_t				issued,
	output	bank_idx_t			even_rd_idx_a,
	output	bank_idx_t			even_rd_idx_b,
	output	bank_idx_t			odd_rd_idx_a,
	output	bank_idx_t			odd_rd_idx_b,
	input	logic [DATA_W-1:0]	even_rd_data_a,
	input	logic [DATA_W-1:0]	even_rd_data_b,
	input	logic [DATA_W-1:0]	odd_rd_data_a,
	input	logic [DATA_W-1:0]	odd_rd_data_b,
	output	fetch_t				fetched
);

	logic [DATA_W-1:0] opnd_a;
	logic [DATA_W-1:0] opnd_b;
	logic [DATA_W-1:0] imm_ext;

	// src1 on port a, src2 on port b of both banks
	assign even_rd_idx_a = bank_idx_t'(issued.cmd.src1 >> 1);
	assign odd_rd_idx_a = bank_idx_t'(issued.cmd.src1 >> 1);
	assign even_rd_idx_b = bank_idx_t'(issued.cmd.src2 >> 1);
	assign odd_rd_idx_b = bank_idx_t'(issued.cmd.src2 >> 1);

	assign imm_ext = {{(DATA_W - 12){issued.cmd.imm[11]}}, issued.cmd.imm};

	assign opnd_a = issued.cmd.src1[0] ? odd_rd_data_a : even_rd_data_a;

	always_comb begin
		if (issued.cmd.opcode == MOVI) begin
			opnd_b = imm_ext;
		end else begin
			opnd_b = issued.cmd.src2[0] ? odd_rd_data_b : even_rd_data_b;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			fetched.issue.valid <= 1'b0;
		end else begin
			fetched.issue.valid <= issued.valid;
		end
		fetched.issue.rd_only <= issued.rd_only;
		fetched.issue.cmd <= issued.cmd;
		fetched.opnd_a <= opnd_a;
		fetched.opnd_b <= opnd_b;
	end

endmodule

// ==== hw/lane_pkg.sv ====
// Lane widths, opcodes, command and pipeline structs, APB structs, address map, opcode helpers
package lane_pkg;

	localparam int DATA_W = 32;
	localparam int NUM_REGS = 16;

	typedef logic [3:0] reg_idx_t;	// Bit 0 picks the bank
	typedef logic [$bits(reg_idx_t)-2:0] bank_idx_t;

	typedef enum logic [3:0] {
		NOP      = 4'd0,
		ADD      = 4'd1,
		SUB      = 4'd2,
		AND      = 4'd3,
		XOR      = 4'd4,
		MOVI     = 4'd5,
		CMPLT    = 4'd6,
		LANE_OFF = 4'd7,
		LANE_ON  = 4'd8
	} opcode_e;

	////////////////////////////////////////
	// Command word and pipeline payloads
	////////////////////////////////////////
	typedef struct packed {
		opcode_e opcode;
		logic masked;
		logic [2:0] spare;
		reg_idx_t dst;
		reg_idx_t src1;
		reg_idx_t src2;
		logic [11:0] imm;
	} cmd_t;

	typedef struct packed {
		logic valid;
		logic rd_only;	// Host register read
		cmd_t cmd;
	} issue_t;

	typedef struct packed {
		issue_t issue;
		logic [DATA_W-1:0] opnd_a;
		logic [DATA_W-1:0] opnd_b;
	} fetch_t;

	typedef struct packed {
		logic valid;
		logic rd_only;
		opcode_e opcode;
		reg_idx_t dst;
		logic masked;
		logic [DATA_W-1:0] data;
		logic cmp;
	} result_t;

	////////////////////////////////////////
	// APB
	////////////////////////////////////////
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [7:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic pready;
		logic [31:0] prdata;
		logic pslverr;
	} apb_rsp_t;

	localparam logic [7:0] ADDR_CMD = 8'h00;
	localparam logic [7:0] ADDR_STATUS = 8'h04;
	localparam logic [7:0] ADDR_REG_BASE = 8'h40;	// Register i at base + 4*i

	// Two-source ops
	function automatic logic reads_srcs(opcode_e op);
		return op inside {ADD, SUB, AND, XOR, CMPLT};
	endfunction

	// Ops that own their dst until retire
	function automatic logic writes_reg(opcode_e op);
		return op inside {ADD, SUB, AND, XOR, MOVI, CMPLT};
	endfunction

endpackage

// ==== hw/lane_reg_bank.sv ====
// Register bank with two asynchronous read ports and one write port
`timescale 1ns/1ps

module lane_reg_bank #(
	parameter int DATA_W = 32,
	parameter int DEPTH = 8
) (
	input	logic						clock,
	input	logic						reset,
	input	logic [$clog2(DEPTH)-1:0]	rd_idx_a,
	input	logic [$clog2(DEPTH)-1:0]	rd_idx_b,
	output	logic [DATA_W-1:0]			rd_data_a,
	output	logic [DATA_W-1:0]			rd_data_b,
	input	logic						wr_en,
	input	logic [$clog2(DEPTH)-1:0]	wr_idx,
	input	logic [DATA_W-1:0]			wr_data
);

	logic [DATA_W-1:0] regs [DEPTH];

	// Registers start at zero
	always_ff @(posedge clock) begin
		if (reset) begin
			regs <= '{default: '0};
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	assign rd_data_a = regs[rd_idx_a];
	assign rd_data_b = regs[rd_idx_b];

endmodule

// ==== hw/lane_writeback.sv ====
// Write-back: lane enable, mask register, masked-write decision, bank write strobes, retire
`timescale 1ns/1ps

module lane_writeback import lane_pkg::*; #(
	parameter int DATA_W = lane_pkg::DATA_W,
	parameter int NUM_REGS = lane_pkg::NUM_REGS
) (
	input	logic					clock,
	input	logic					reset,
	input	result_t				result,
	output	logic					even_wr_en,
	output	bank_idx_t				even_wr_idx,
	output	logic [DATA_W-1:0]		even_wr_data,
	output	logic					odd_wr_en,
	output	bank_idx_t				odd_wr_idx,
	output	logic [DATA_W-1:0]		odd_wr_data,
	output	logic					retire,
	output	reg_idx_t				retire_dst,
	output	logic					read_done,
	output	logic [DATA_W-1:0]		read_data,
	output	logic					lane_en,
	output	logic [NUM_REGS-1:0]	mask
);

	logic cmd_live;	// Command that takes effect
	logic mask_ok;
	logic do_write;

	assign cmd_live = result.valid & ~result.rd_only & lane_en;
	assign mask_ok = ~result.masked | mask[result.dst];
	assign do_write = cmd_live & mask_ok & writes_reg(result.opcode) &
		(result.opcode != CMPLT);

	////////////////////////////////////////
	// Bank writes
	////////////////////////////////////////
	assign even_wr_en = do_write & ~result.dst[0];
	assign odd_wr_en = do_write & result.dst[0];
	assign even_wr_idx = bank_idx_t'(result.dst >> 1);
	assign odd_wr_idx = bank_idx_t'(result.dst >> 1);
	assign even_wr_data = result.data;
	assign odd_wr_data = result.data;

	// Retire even while disabled
	assign retire = result.valid & ~result.rd_only & writes_reg(result.opcode);
	assign retire_dst = result.dst;

	assign read_done = result.valid & result.rd_only;
	assign read_data = result.data;

	always_ff @(posedge clock) begin
		if (reset) begin
			lane_en <= 1'b1;
			mask <= '0;
		end else if (result.valid & ~result.rd_only) begin
			case (result.opcode)
				LANE_OFF: lane_en <= 1'b0;
				LANE_ON: lane_en <= 1'b1;
				CMPLT: begin
					if (lane_en) begin
						mask[result.dst] <= result.cmp;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== lane_core.f ====
hw/lane_pkg.sv
hw/lane_reg_bank.sv
hw/lane_apb_port.sv
hw/lane_issue.sv
hw/lane_operand_fetch.sv
hw/lane_exec.sv
hw/lane_writeback.sv
hw/lane_core.sv
dv/lane_core_tb.sv
